// File: Bender.yml
package:
  name: slapstikBank

sources:
  - logic/slapstikPkg.sv
  - logic/slapstikSequencer.sv
  - logic/romWindowMapper.sv
  - logic/protRegs.sv
  - logic/slapstikTop.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/slapstikTb.sv

// File: logic/protRegs.sv
// APB register block that steers the sequencer and reports bank, state and switch count
`timescale 1ns/1ps

module protRegs (
	input logic CLK,
	input logic RST,
	input slapstikPkg::apbReqT apbReq,
	output slapstikPkg::apbRspT apbRsp,
	input slapstikPkg::seqStatusT status,
	output slapstikPkg::seqCtrlT ctrl
);

	slapstikPkg::apbAddrT regAddr;
	slapstikPkg::apbDataT readData;
	slapstikPkg::switchCountT switchCount;
	logic enable;
	logic access;
	logic addrOk;
	logic wrCtrl;
	logic wrBank;
	logic wrCount;

	assign access = apbReq.psel & apbReq.penable;
	assign regAddr = apbReq.paddr[3:0];

	always_comb begin
		addrOk = 1'b0;
		readData = '0;
		if (apbReq.paddr[31:4] == '0) begin
			case (regAddr)
				slapstikPkg::REG_CTRL: begin
					addrOk = 1'b1;
					readData = {31'b0, enable};	// soft reset bit reads as 0
				end
				slapstikPkg::REG_BANK: begin
					addrOk = 1'b1;
					readData = {30'b0, status.bank};
				end
				slapstikPkg::REG_STATUS: begin
					addrOk = 1'b1;
					readData = {29'b0, status.state};
				end
				slapstikPkg::REG_COUNT: begin
					addrOk = 1'b1;
					readData = {16'b0, switchCount};
				end
				default: ;
			endcase
		end
	end

	assign wrCtrl = access & apbReq.pwrite & addrOk & (regAddr == slapstikPkg::REG_CTRL);
	assign wrBank = access & apbReq.pwrite & addrOk & (regAddr == slapstikPkg::REG_BANK);
	assign wrCount = access & apbReq.pwrite & addrOk & (regAddr == slapstikPkg::REG_COUNT);

	always_ff @(posedge CLK) begin
		if (RST) begin
			enable <= 1'b1;
		end else if (wrCtrl) begin
			enable <= apbReq.pwdata[0];
		end
	end

	// saturating count of sequence driven switches
	always_ff @(posedge CLK) begin
		if (RST) begin
			switchCount <= '0;
		end else if (wrCount) begin
			switchCount <= '0;
		end else if (status.switched && switchCount != '1) begin
			switchCount <= switchCount + 1'b1;
		end
	end

	// pulses line up with the edge that ends the access phase
	assign ctrl = '{
		enable: enable,
		softReset: wrCtrl & apbReq.pwdata[1],
		bankLoad: wrBank,
		bankValue: apbReq.pwdata[1:0]
	};

	assign apbRsp = '{
		prdata: (apbReq.psel & ~apbReq.pwrite) ? readData : '0,
		pready: 1'b1,
		pslverr: access & ~addrOk
	};

endmodule

// File: logic/romWindowMapper.sv
// registered translation of CPU window offsets into cartridge ROM addresses
`timescale 1ns/1ps

module romWindowMapper (
	input logic CLK,
	input logic RST,
	input slapstikPkg::cpuAccessT access,
	input slapstikPkg::bankT bank,
	output slapstikPkg::romAddrT romAddr,
	output logic romValid
);

	slapstikPkg::romAddrT mapped;
	slapstikPkg::romAddrT offset;
	logic hit;

	assign hit = access.sel & access.strobe;
	assign offset = slapstikPkg::romAddrT'(access.addr);

	// low 2 KB follows the bank, the rest is a fixed region
	always_comb begin
		if (access.addr[12:11] == 2'b00) begin
			mapped = {bank, access.addr[10:0]};
		end else begin
			mapped = slapstikPkg::FIXED_BASE + offset - slapstikPkg::BANK_SPAN;
		end
	end

	always_ff @(posedge CLK) begin
		if (RST) begin
			romValid <= 1'b0;
		end else begin
			romValid <= hit;
		end
	end

	always_ff @(posedge CLK) begin
		if (hit) begin
			romAddr <= mapped;	// held until the next access
		end
	end

	validNeedsStrobes: assert property (@(posedge CLK) disable iff (RST)
		(romValid && $past(romValid)) |-> ($past(access.strobe, 1) && $past(access.strobe, 2)));

endmodule

// File: logic/slapstikPkg.sv
// shared widths, address constants, state encoding and bus structs for the slapstik protection unit
package slapstikPkg;

	typedef logic [12:0] cpuAddrT;	// offset inside the 8 KB window
	typedef logic [1:0] bankT;
	typedef logic [13:0] romAddrT;
	typedef logic [3:0] apbAddrT;	// register byte offset
	typedef logic [31:0] apbDataT;
	typedef logic [15:0] switchCountT;

	typedef struct packed {
		cpuAddrT mask;
		cpuAddrT value;
	} addrMatchT;

	localparam bankT INIT_BANK = 2'd3;

	localparam cpuAddrT SEQ_RESET_ADDR = 13'h0000;
	localparam cpuAddrT BANK_SEL_ADDR0 = 13'h0080;	// bits 5:4 carry the bank
	localparam cpuAddrT BANK_SEL_ADDR1 = 13'h0090;
	localparam cpuAddrT BANK_SEL_ADDR2 = 13'h00A0;
	localparam cpuAddrT BANK_SEL_ADDR3 = 13'h00B0;

	// masked value stays below 0x80 so this pair never hits
	localparam addrMatchT AT1 = '{mask: 13'h007F, value: 13'h1FFF};
	localparam addrMatchT AT2 = '{mask: 13'h1FFF, value: 13'h1DFF};
	localparam addrMatchT AT3 = '{mask: 13'h1FFC, value: 13'h1B5C};	// low bits pick the bank
	localparam addrMatchT AT4 = '{mask: 13'h1FCF, value: 13'h0080};

	localparam addrMatchT BW1 = '{mask: 13'h1FF0, value: 13'h1540};
	localparam addrMatchT BW2 = '{mask: 13'h1FF3, value: 13'h1540};	// bits 1:0 select the action
	localparam addrMatchT BW3 = '{mask: 13'h1FF8, value: 13'h1550};

	localparam romAddrT FIXED_BASE = 14'h2000;
	localparam romAddrT BANK_SPAN = 14'h0800;	// size of one switched bank

	localparam apbAddrT REG_CTRL = 4'h0;
	localparam apbAddrT REG_BANK = 4'h4;
	localparam apbAddrT REG_STATUS = 4'h8;
	localparam apbAddrT REG_COUNT = 4'hC;

	typedef enum logic [2:0] {
		sDisabled,
		sEnabled,
		sAdd1,
		sAdd2,
		sAdd3,
		sBit1,
		sBit2,
		sBit3
	} seqStateT;

	typedef struct packed {
		logic sel;
		logic strobe;
		cpuAddrT addr;
	} cpuAccessT;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apbDataT paddr;	// full bus address, registers sit in the low nibble
		apbDataT pwdata;
	} apbReqT;

	typedef struct packed {
		apbDataT prdata;
		logic pready;
		logic pslverr;
	} apbRspT;

	typedef struct packed {
		logic enable;
		logic softReset;
		logic bankLoad;
		bankT bankValue;
	} seqCtrlT;

	typedef struct packed {
		bankT bank;
		seqStateT state;
		logic switched;
	} seqStatusT;

	function automatic logic addrHit(cpuAddrT addr, addrMatchT pair);
		return (addr & pair.mask) == pair.value;
	endfunction

endpackage

// File: logic/slapstikSequencer.sv
// protection FSM that follows the CPU access sequences and holds the current ROM bank
`timescale 1ns/1ps

module slapstikSequencer (
	input logic CLK,
	input logic RST,
	input slapstikPkg::cpuAccessT access,
	input slapstikPkg::seqCtrlT ctrl,
	output slapstikPkg::seqStatusT status
);

	slapstikPkg::seqStateT stateQ;
	slapstikPkg::bankT bankQ;
	slapstikPkg::bankT addBank;	// bank captured from the AT3 access
	slapstikPkg::bankT bitBank;	// working value of the bitwise path
	logic toggle;
	logic switchedQ;
	logic hit;
	logic isArm;
	logic isBankSel;
	logic bw2Hit;
	logic [1:0] bitSel;
	slapstikPkg::cpuAddrT addr;

	assign addr = access.addr;
	assign hit = access.sel & access.strobe & ctrl.enable;
	assign isArm = addr == slapstikPkg::SEQ_RESET_ADDR;
	assign isBankSel = (addr == slapstikPkg::BANK_SEL_ADDR0) |
		(addr == slapstikPkg::BANK_SEL_ADDR1) |
		(addr == slapstikPkg::BANK_SEL_ADDR2) |
		(addr == slapstikPkg::BANK_SEL_ADDR3);

	// BW2 covers four neighbours, the toggled low bits say which one
	assign bw2Hit = ((addr & slapstikPkg::BW2.mask) & 13'h1FFC) == slapstikPkg::BW2.value;
	assign bitSel = addr[1:0] ^ {toggle, toggle};

	always_ff @(posedge CLK) begin
		if (RST) begin
			stateQ <= slapstikPkg::sDisabled;
			bankQ <= slapstikPkg::INIT_BANK;
			toggle <= 1'b0;
			switchedQ <= 1'b0;
		end else begin
			switchedQ <= 1'b0;
			if (ctrl.softReset) begin
				stateQ <= slapstikPkg::sDisabled;	// bank is left alone
				toggle <= 1'b0;
			end else if (ctrl.bankLoad) begin
				bankQ <= ctrl.bankValue;
			end else if (hit) begin
				if (isArm) begin
					stateQ <= slapstikPkg::sEnabled;
				end else begin
					case (stateQ)
						slapstikPkg::sEnabled: begin
							if (isBankSel) begin
								bankQ <= addr[5:4];
								stateQ <= slapstikPkg::sDisabled;
								switchedQ <= 1'b1;
							end else if (slapstikPkg::addrHit(addr, slapstikPkg::AT1)) begin
								stateQ <= slapstikPkg::sAdd1;
							end else if (slapstikPkg::addrHit(addr, slapstikPkg::AT2)) begin
								stateQ <= slapstikPkg::sAdd2;
							end else if (slapstikPkg::addrHit(addr, slapstikPkg::BW1)) begin
								stateQ <= slapstikPkg::sBit1;
							end
						end
						slapstikPkg::sAdd1: begin
							if (slapstikPkg::addrHit(addr, slapstikPkg::AT2)) begin
								stateQ <= slapstikPkg::sAdd2;
							end else begin
								stateQ <= slapstikPkg::sEnabled;
							end
						end
						slapstikPkg::sAdd2: begin
							if (slapstikPkg::addrHit(addr, slapstikPkg::AT3)) begin
								addBank <= addr[1:0];
								stateQ <= slapstikPkg::sAdd3;
							end else begin
								stateQ <= slapstikPkg::sEnabled;
							end
						end
						slapstikPkg::sAdd3: begin
							if (slapstikPkg::addrHit(addr, slapstikPkg::AT4)) begin
								bankQ <= addBank;
								stateQ <= slapstikPkg::sDisabled;
								switchedQ <= 1'b1;
							end
						end
						slapstikPkg::sBit1: begin
							if (isBankSel) begin
								bitBank <= bankQ;
								toggle <= 1'b0;
								stateQ <= slapstikPkg::sBit2;
							end
						end
						slapstikPkg::sBit2: begin
							if (bw2Hit) begin
								bitBank[bitSel[1]] <= bitSel[0];	// bit index, then set or clear
								toggle <= ~toggle;
							end else if (slapstikPkg::addrHit(addr, slapstikPkg::BW3)) begin
								stateQ <= slapstikPkg::sBit3;
							end
						end
						slapstikPkg::sBit3: begin
							if (isBankSel) begin
								bankQ <= bitBank;
								stateQ <= slapstikPkg::sDisabled;
								switchedQ <= 1'b1;
							end
						end
						default: ;	// disabled waits for the arm offset
					endcase
				end
			end
		end
	end

	assign status = '{bank: bankQ, state: stateQ, switched: switchedQ};

	stateKnown: assert property (@(posedge CLK) disable iff (RST) !$isunknown(stateQ));

	noSwitchAfterSoftReset: assert property (@(posedge CLK) disable iff (RST)
		ctrl.softReset |=> !status.switched);

endmodule

// File: logic/slapstikTop.sv
// top level of the protection unit, joining the ROM mapper, the sequencer and the APB registers
`timescale 1ns/1ps

module slapstikTop (
	input logic CLK,
	input logic RST,
	input slapstikPkg::cpuAccessT cpu,
	input slapstikPkg::apbReqT apbReq,
	output slapstikPkg::apbRspT apbRsp,
	output slapstikPkg::romAddrT romAddr,
	output logic romValid
);

	slapstikPkg::seqCtrlT seqCtrl;
	slapstikPkg::seqStatusT seqStatus;

	slapstikSequencer sequencer (
		.CLK(CLK),
		.RST(RST),
		.access(cpu),
		.ctrl(seqCtrl),
		.status(seqStatus)
	);

	// mapper sees the bank from before the sequencer edge
	romWindowMapper mapper (
		.CLK(CLK),
		.RST(RST),
		.access(cpu),
		.bank(seqStatus.bank),
		.romAddr(romAddr),
		.romValid(romValid)
	);

	protRegs regs (
		.CLK(CLK),
		.RST(RST),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.status(seqStatus),
		.ctrl(seqCtrl)
	);

endmodule

// File: sim/clockGen.sv
// testbench clock and reset source, 100 ns period with reset held for two cycles
`timescale 1ns/1ps

module clockGen (
	output logic CLK,
	output logic RST
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		RST = 1'b1;
		repeat (2) @(posedge CLK);
		#1;
		RST = 1'b0;	// released just after the second edge
	end

endmodule

// File: sim/slapstikTb.sv
// table-driven testbench for slapstikTop, checks banking, ROM mapping and the APB registers
`timescale 1ns/1ps

module slapstikTb;

	typedef struct packed {
		slapstikPkg::cpuAddrT addr;
		slapstikPkg::bankT bank;
		slapstikPkg::seqStateT state;
	} rowT;

	logic CLK;
	logic RST;
	slapstikPkg::cpuAccessT cpu;
	slapstikPkg::apbReqT apbReq;
	slapstikPkg::apbRspT apbRsp;
	slapstikPkg::romAddrT romAddr;
	logic romValid;
	rowT rows[$];
	int mismatches;
	int timeouts;

	// reference model of the bank rules
	slapstikPkg::bankT mBank;
	slapstikPkg::bankT mWork;
	slapstikPkg::bankT mAdd;
	slapstikPkg::seqStateT mState;
	logic mToggle;
	logic mEnable;
	int mCount;

	clockGen clocks (.CLK(CLK), .RST(RST));

	slapstikTop uut (
		.CLK(CLK),
		.RST(RST),
		.cpu(cpu),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.romAddr(romAddr),
		.romValid(romValid)
	);

	task automatic reportMismatch(input string msg, input logic [31:0] got,
		input logic [31:0] exp);
		$display("MISMATCH @%0t: %s got %h expected %h", $time, msg, got, exp);
		mismatches++;
	endtask

	function automatic slapstikPkg::romAddrT mapAddr(slapstikPkg::cpuAddrT a,
		slapstikPkg::bankT b);
		if (a[12:11] == 2'b00) begin
			return slapstikPkg::romAddrT'(b) * 14'd2048 + slapstikPkg::romAddrT'(a);
		end
		return slapstikPkg::FIXED_BASE + slapstikPkg::romAddrT'(a) - 14'h0800;
	endfunction

	task automatic commitBank(input slapstikPkg::bankT b);
		mBank = b;
		mState = slapstikPkg::sDisabled;
		mCount = mCount + 1;
	endtask

	task automatic modelStep(input slapstikPkg::cpuAddrT a);
		logic [1:0] s;
		logic bankSel;
		s = a[1:0] ^ {mToggle, mToggle};
		bankSel = (a == 13'h0080) || (a == 13'h0090) ||
			(a == 13'h00A0) || (a == 13'h00B0);
		if (mEnable) begin
			if (a == 13'h0000) begin
				mState = slapstikPkg::sEnabled;
			end else begin
				case (mState)
					slapstikPkg::sEnabled: begin
						if (bankSel) begin
							commitBank(a[5:4]);
						end else if (a == 13'h1DFF) begin
							mState = slapstikPkg::sAdd2;
						end else if (a[12:4] == 9'h154) begin
							mState = slapstikPkg::sBit1;
						end
					end
					slapstikPkg::sAdd2: begin
						if (a[12:2] == 11'h6D7) begin
							mAdd = a[1:0];
							mState = slapstikPkg::sAdd3;
						end else begin
							mState = slapstikPkg::sEnabled;
						end
					end
					slapstikPkg::sAdd3: begin
						if (bankSel) begin
							commitBank(mAdd);
						end
					end
					slapstikPkg::sBit1: begin
						if (bankSel) begin
							mWork = mBank;
							mToggle = 1'b0;
							mState = slapstikPkg::sBit2;
						end
					end
					slapstikPkg::sBit2: begin
						if (a[12:4] == 9'h154) begin
							mWork[s[1]] = s[0];	// toggled bits pick index and value
							mToggle = ~mToggle;
						end else if (a[12:3] == 10'h2AA) begin
							mState = slapstikPkg::sBit3;
						end
					end
					slapstikPkg::sBit3: begin
						if (bankSel) begin
							commitBank(mWork);
						end
					end
					default: ;
				endcase
			end
		end
	endtask

	task automatic cpuAccess(input slapstikPkg::cpuAddrT a);
		slapstikPkg::romAddrT expAddr;
		int waited;
		expAddr = mapAddr(a, mBank);	// bank from before the access
		@(posedge CLK);
		#1;
		cpu = '{sel: 1'b1, strobe: 1'b1, addr: a};
		@(posedge CLK);
		#1;
		cpu = '0;
		modelStep(a);
		waited = 0;
		while (!romValid && waited < 10) begin
			@(posedge CLK);
			#1;
			waited++;
		end
		if (!romValid) begin
			$display("ERROR @%0t: romValid never arrived for offset %h", $time, a);
			timeouts++;
		end else begin
			if (waited != 0) reportMismatch("romValid latency in cycles", waited + 1, 1);
			if (romAddr !== expAddr) begin
				reportMismatch($sformatf("romAddr for %h", a), romAddr, expAddr);
			end
			@(posedge CLK);
			#1;
			if (romValid !== 1'b0) reportMismatch("romValid held a second cycle", romValid, 0);
		end
	endtask

	task automatic apbTransfer(input logic write, input slapstikPkg::apbDataT addr,
		input slapstikPkg::apbDataT wdata, input logic expErr, output slapstikPkg::apbDataT rdata);
		@(posedge CLK);
		#1;
		apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge CLK);
		#1;
		apbReq.penable = 1'b1;
		#10;	// sample mid access phase
		rdata = apbRsp.prdata;
		if (apbRsp.pready !== 1'b1) reportMismatch("pready", apbRsp.pready, 1);
		if (apbRsp.pslverr !== expErr) begin
			reportMismatch($sformatf("pslverr at %h", addr), apbRsp.pslverr, expErr);
		end
		@(posedge CLK);
		#1;
		apbReq = '0;
	endtask

	task automatic apbWrite(input slapstikPkg::apbDataT addr, input slapstikPkg::apbDataT data,
		input logic expErr);
		slapstikPkg::apbDataT unused;
		apbTransfer(1'b1, addr, data, expErr, unused);
	endtask

	task automatic checkReg(input slapstikPkg::apbDataT addr, input slapstikPkg::apbDataT exp,
		input string msg);
		slapstikPkg::apbDataT data;
		apbTransfer(1'b0, addr, '0, 1'b0, data);
		if (data !== exp) reportMismatch(msg, data, exp);
	endtask

	initial begin
		int i;
		int waited;
		logic [31:0] off;
		slapstikPkg::apbDataT data;
		slapstikPkg::bankT forced;
		cpu = '0;
		apbReq = '0;
		mismatches = 0;
		timeouts = 0;
		mBank = slapstikPkg::INIT_BANK;
		mWork = '0;
		mAdd = '0;
		mState = slapstikPkg::sDisabled;
		mToggle = 1'b0;
		mEnable = 1'b1;
		mCount = 0;
		void'($urandom(32'hf3e92444));

		// offset, bank after the row, state after the row
		rows.push_back('{13'h0000, 2'd3, slapstikPkg::sEnabled});
		rows.push_back('{13'h00A0, 2'd2, slapstikPkg::sDisabled});
		rows.push_back('{13'h0090, 2'd2, slapstikPkg::sDisabled});	// not armed
		rows.push_back('{13'h0000, 2'd2, slapstikPkg::sEnabled});
		rows.push_back('{13'h1DFF, 2'd2, slapstikPkg::sAdd2});
		rows.push_back('{13'h1B5D, 2'd2, slapstikPkg::sAdd3});
		rows.push_back('{13'h0080, 2'd1, slapstikPkg::sDisabled});
		rows.push_back('{13'h0000, 2'd1, slapstikPkg::sEnabled});
		rows.push_back('{13'h1DFF, 2'd1, slapstikPkg::sAdd2});
		rows.push_back('{13'h1B00, 2'd1, slapstikPkg::sEnabled});	// wrong AT3 offset
		rows.push_back('{13'h0000, 2'd1, slapstikPkg::sEnabled});
		rows.push_back('{13'h1540, 2'd1, slapstikPkg::sBit1});
		rows.push_back('{13'h0080, 2'd1, slapstikPkg::sBit2});
		rows.push_back('{13'h1543, 2'd1, slapstikPkg::sBit2});
		rows.push_back('{13'h1541, 2'd1, slapstikPkg::sBit2});
		rows.push_back('{13'h1540, 2'd1, slapstikPkg::sBit2});
		rows.push_back('{13'h1540, 2'd1, slapstikPkg::sBit2});
		rows.push_back('{13'h1550, 2'd1, slapstikPkg::sBit3});
		rows.push_back('{13'h00B0, 2'd2, slapstikPkg::sDisabled});

		waited = 0;
		while (RST !== 1'b0 && waited < 10) begin
			@(negedge CLK);
			waited++;
		end
		if (RST !== 1'b0) begin
			$display("ERROR @%0t: reset was never released", $time);
			timeouts++;
		end

		if (romValid !== 1'b0) reportMismatch("romValid after reset", romValid, 0);
		checkReg(slapstikPkg::REG_CTRL, 32'h1, "enable after reset");
		checkReg(slapstikPkg::REG_BANK, 32'h3, "bank after reset");
		checkReg(slapstikPkg::REG_STATUS, slapstikPkg::sDisabled, "state after reset");
		checkReg(slapstikPkg::REG_COUNT, 32'h0, "count after reset");

		for (i = 0; i < rows.size(); i++) begin
			cpuAccess(rows[i].addr);
			checkReg(slapstikPkg::REG_BANK, rows[i].bank, $sformatf("row %0d bank", i));
			checkReg(slapstikPkg::REG_STATUS, rows[i].state, $sformatf("row %0d state", i));
			if (rows[i].bank !== mBank) begin
				reportMismatch($sformatf("row %0d model bank", i), mBank, rows[i].bank);
			end
		end
		checkReg(slapstikPkg::REG_COUNT, 32'd3, "count after table");

		// random banked and fixed offsets
		for (i = 0; i < 16; i++) begin
			if (i % 2 == 0) begin
				off = $urandom % 32'h0800;
			end else begin
				off = 32'h0800 + $urandom % 32'h1800;
			end
			cpuAccess(off[12:0]);
		end
		checkReg(slapstikPkg::REG_BANK, mBank, "bank after random offsets");

		apbWrite(slapstikPkg::REG_CTRL, 32'h0, 1'b0);
		mEnable = 1'b0;
		checkReg(slapstikPkg::REG_CTRL, 32'h0, "enable cleared");
		cpuAccess(13'h0000);
		cpuAccess(13'h0090);
		checkReg(slapstikPkg::REG_BANK, mBank, "bank while disabled");
		checkReg(slapstikPkg::REG_STATUS, mState, "state while disabled");
		apbWrite(slapstikPkg::REG_CTRL, 32'h1, 1'b0);
		mEnable = 1'b1;

		forced = mBank ^ 2'b01;
		apbWrite(slapstikPkg::REG_BANK, forced, 1'b0);
		mBank = forced;
		checkReg(slapstikPkg::REG_BANK, forced, "forced bank");
		checkReg(slapstikPkg::REG_COUNT, mCount, "count after forced load");

		cpuAccess(13'h0000);
		checkReg(slapstikPkg::REG_STATUS, slapstikPkg::sEnabled, "armed before soft reset");
		apbWrite(slapstikPkg::REG_CTRL, 32'h3, 1'b0);
		mState = slapstikPkg::sDisabled;
		mToggle = 1'b0;
		checkReg(slapstikPkg::REG_STATUS, slapstikPkg::sDisabled, "state after soft reset");
		checkReg(slapstikPkg::REG_CTRL, 32'h1, "soft reset bit reads 0");

		cpuAccess(13'h0000);
		cpuAccess(13'h00A0);
		checkReg(slapstikPkg::REG_COUNT, mCount, "switch count");
		apbWrite(slapstikPkg::REG_COUNT, 32'h1234, 1'b0);
		mCount = 0;
		checkReg(slapstikPkg::REG_COUNT, 32'h0, "count after clear");

		// a zero write would clear enable if 0x10 aliased onto REG_CTRL
		apbWrite(32'h10, 32'h0, 1'b1);
		apbTransfer(1'b0, 32'h10, '0, 1'b1, data);
		if (data !== 32'h0) reportMismatch("read of unmapped address", data, 0);
		checkReg(slapstikPkg::REG_CTRL, 32'h1, "ctrl after unmapped write");
		checkReg(slapstikPkg::REG_BANK, mBank, "bank after unmapped write");

		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches + timeouts == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: slapstikBank.f
logic/slapstikPkg.sv
logic/slapstikSequencer.sv
logic/romWindowMapper.sv
logic/protRegs.sv
logic/slapstikTop.sv
sim/clockGen.sv
sim/slapstikTb.sv
